//--- Bender.yml
package:
  name: bbcMemSubsystem

sources:
  - files:
      - rtl/bbcMemPkg.sv
      - rtl/cpuBusIf.sv
      - rtl/sheilaDecoder.sv
      - rtl/systemControlRegs.sv
      - rtl/screenAddrMapper.sv
      - rtl/memoryArbiter.sv
      - rtl/bbcMemSubsystem.sv
  - target: test
    files:
      - dv/bbcMemSubsystem_assert.sv
      - dv/bbcMemTb.sv

//--- dv/bbcMemSubsystem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module bbcMemSubsystem_assert (
	input logic clk2MHz,
	input logic [7:0] cpuReadData,
	input logic cpuReadHit,
	input logic [7:0] videoData,
	input logic videoValid,
	input logic romOs,
	input logic [13:0] romAddr,
	input logic autoscan,
	// Active-low selects, crtc in the top bit
	input logic [8:0] selects,
	input logic checkRead,
	input logic checkSheila,
	input logic checkDecode,
	input logic checkVideo,
	input logic checkReset,
	input logic latchCheckOn,
	input logic [7:0] expReadData,
	input logic [7:0] expVideoData,
	input logic [8:0] expSelect,
	input logic expRomOs,
	input logic [13:0] expRomAddr,
	input logic expAutoscan
);

	int failCount = 0;

	readDataMatch: assert property (@(posedge clk2MHz) checkRead |-> cpuReadData == expReadData)
		else begin
			$error("cpuReadData 0x%h, expected 0x%h", $sampled(cpuReadData),
				$sampled(expReadData));
			failCount++;
		end

	readHitHigh: assert property (@(posedge clk2MHz) checkRead |-> cpuReadHit)
		else begin
			$error("cpuReadHit stayed low after a memory read");
			failCount++;
		end

	// FE page reads belong to the peripherals
	sheilaNoHit: assert property (@(posedge clk2MHz) checkSheila |-> !cpuReadHit)
		else begin
			$error("cpuReadHit went high after an I/O page read");
			failCount++;
		end

	selectMatch: assert property (@(posedge clk2MHz) checkDecode |-> selects == expSelect)
		else begin
			$error("ioSelect 0x%h, expected 0x%h", $sampled(selects), $sampled(expSelect));
			failCount++;
		end

	romOsMatch: assert property (@(posedge clk2MHz) checkDecode |-> romOs == expRomOs)
		else begin
			$error("romOs 0x%h, expected 0x%h", $sampled(romOs), $sampled(expRomOs));
			failCount++;
		end

	romAddrMatch: assert property (@(posedge clk2MHz) checkDecode |-> romAddr == expRomAddr)
		else begin
			$error("romAddr 0x%h, expected 0x%h", $sampled(romAddr), $sampled(expRomAddr));
			failCount++;
		end

	autoscanMatch: assert property (@(posedge clk2MHz) latchCheckOn |-> autoscan == expAutoscan)
		else begin
			$error("autoscan 0x%h, expected 0x%h", $sampled(autoscan), $sampled(expAutoscan));
			failCount++;
		end

	videoDataMatch: assert property (@(posedge clk2MHz) checkVideo |-> videoData == expVideoData)
		else begin
			$error("videoData 0x%h, expected 0x%h", $sampled(videoData),
				$sampled(expVideoData));
			failCount++;
		end

	videoValidHigh: assert property (@(posedge clk2MHz) checkVideo |-> videoValid)
		else begin
			$error("videoValid stayed low after a video cycle");
			failCount++;
		end

	resetQuiet: assert property (@(posedge clk2MHz)
		checkReset |-> !cpuReadHit && !videoValid && !autoscan)
		else begin
			$error("a status output went high during or right after reset");
			failCount++;
		end

endmodule

`default_nettype wire

//--- dv/bbcMemTb.sv
`timescale 1ns/1ps
`default_nettype none

module bbcMemTb import bbcMemPkg::*; ();

	// Roughly twice the length of all tests
	localparam int cycleLimit = 2000;
	localparam logic [3:0] wrapTable [4] = '{4'd8, 4'd12, 4'd6, 4'd11};

	logic clk2MHz;
	logic CPU_RESETN;
	logic [addrWidth-1:0] addr;
	logic [dataWidth-1:0] writeData;
	logic rnw;
	logic phi2;
	logic latchWrite;
	logic [2:0] latchAddr;
	logic latchData;
	logic [13:0] framestoreAddr;
	logic [2:0] rowAddr;
	logic [dataWidth-1:0] romData;
	logic [13:0] romAddr;
	logic romOs;
	logic [dataWidth-1:0] cpuReadData;
	logic cpuReadHit;
	logic [dataWidth-1:0] videoData;
	logic videoValid;
	logic nCrtc;
	logic nAcia;
	logic nVideoUla;
	logic nRomSelect;
	logic nVia;
	logic nUserVia;
	logic nFdc;
	logic nAdc;
	logic nTube;
	logic autoscan;

	// Expected values and check enables seen by the bound assertions
	logic checkRead;
	logic checkSheila;
	logic checkDecode;
	logic checkVideo;
	logic checkReset;
	logic latchCheckOn;
	logic [7:0] expReadData;
	logic [7:0] expVideoData;
	logic [8:0] expSelect;
	logic expRomOs;
	logic [13:0] expRomAddr;
	logic [7:0] shadowLatch;
	logic [7:0] shadowRam [2**ramAddrWidth];

	int seed;
	int cycleCount;
	int failsBefore;
	int passedTests;
	int failedTests;

	bbcMemSubsystem bbcMemSubsystem_inst (.*);

	bind bbcMemSubsystem bbcMemSubsystem_assert assertInst (
		.clk2MHz,
		.cpuReadData,
		.cpuReadHit,
		.videoData,
		.videoValid,
		.romOs,
		.romAddr,
		.autoscan,
		.selects({nCrtc, nAcia, nVideoUla, nRomSelect, nVia, nUserVia, nFdc, nAdc, nTube}),
		.checkRead(bbcMemTb.checkRead),
		.checkSheila(bbcMemTb.checkSheila),
		.checkDecode(bbcMemTb.checkDecode),
		.checkVideo(bbcMemTb.checkVideo),
		.checkReset(bbcMemTb.checkReset),
		.latchCheckOn(bbcMemTb.latchCheckOn),
		.expReadData(bbcMemTb.expReadData),
		.expVideoData(bbcMemTb.expVideoData),
		.expSelect(bbcMemTb.expSelect),
		.expRomOs(bbcMemTb.expRomOs),
		.expRomAddr(bbcMemTb.expRomAddr),
		.expAutoscan(bbcMemTb.shadowLatch[3])
	);

	// ROM image: low address byte XOR 5A, inverted for the OS ROM
	function automatic logic [7:0] romModel(input logic [7:0] low, input logic os);
		logic [7:0] value;
		value = low ^ 8'h5A;
		return os ? ~value : value;
	endfunction

	assign romData = romModel(romAddr[7:0], romOs);

	function automatic logic expectedRomOs(input logic [15:0] a);
		return (a >= 16'hC000) && (a[15:8] != 8'hFE);
	endfunction

	function automatic logic [8:0] expectedSelects(input logic [15:0] a, input logic r);
		logic [8:0] sel;
		sel = '1;
		if (a[15:8] == 8'hFE) begin
			// Write-only selects stay high on reads
			case (a[7:0]) inside
				[8'h00:8'h07]: sel[8] = 1'b0;
				[8'h08:8'h0F]: sel[7] = 1'b0;
				[8'h20:8'h2F]: sel[6] = r;
				[8'h30:8'h3F]: sel[5] = r;
				[8'h40:8'h5F]: sel[4] = 1'b0;
				[8'h60:8'h7F]: sel[3] = 1'b0;
				[8'h80:8'h9F]: sel[2] = 1'b0;
				[8'hC0:8'hDF]: sel[1] = 1'b0;
				[8'hE0:8'hFF]: sel[0] = 1'b0;
				default: ;
			endcase
		end
		return sel;
	endfunction

	initial begin
		clk2MHz = 1'b0;
		forever #2 clk2MHz = ~clk2MHz;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk2MHz);
			cycleCount++;
		end
		$display("Timeout: the tests did not end within %0d cycles", cycleLimit);
		$display("Finished with errors");
		$finish;
	end

	// Bus goes back to the video phase, all one-cycle checks off
	task automatic idle();
		@(posedge clk2MHz);
		phi2 <= 1'b0;
		rnw <= 1'b1;
		latchWrite <= 1'b0;
		checkRead <= 1'b0;
		checkSheila <= 1'b0;
		checkDecode <= 1'b0;
		checkVideo <= 1'b0;
	endtask

	task automatic cpuWrite(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk2MHz);
		addr <= a;
		writeData <= d;
		rnw <= 1'b0;
		phi2 <= 1'b1;
		if (a < 16'h8000) begin
			shadowRam[a[14:0]] = d;
		end
		idle();
	endtask

	task automatic cpuRead(input logic [15:0] a, input logic [7:0] expected);
		logic inSheila;
		inSheila = (a[15:8] == 8'hFE);
		@(posedge clk2MHz);
		addr <= a;
		rnw <= 1'b1;
		phi2 <= 1'b1;
		checkDecode <= 1'b1;
		expSelect <= expectedSelects(a, 1'b1);
		expRomOs <= expectedRomOs(a);
		expRomAddr <= a[13:0];
		// Data is registered one clock after the read cycle
		@(posedge clk2MHz);
		phi2 <= 1'b0;
		checkRead <= ~inSheila;
		checkSheila <= inSheila;
		expReadData <= expected;
		idle();
	endtask

	task automatic decodeStep(input logic [15:0] a, input logic r);
		@(posedge clk2MHz);
		addr <= a;
		rnw <= r;
		phi2 <= 1'b0;
		checkDecode <= 1'b1;
		expSelect <= expectedSelects(a, r);
		expRomOs <= expectedRomOs(a);
		expRomAddr <= a[13:0];
	endtask

	task automatic latchOp(input logic [2:0] a, input logic d);
		@(posedge clk2MHz);
		latchWrite <= 1'b1;
		latchAddr <= a;
		latchData <= d;
		@(posedge clk2MHz);
		latchWrite <= 1'b0;
		shadowLatch[a] = d;
	endtask

	task automatic videoCheck(input logic [13:0] fs, input logic [2:0] row);
		logic [3:0] nibble;
		logic [14:0] ramA;
		nibble = fs[11:8];
		if (fs[12]) begin
			nibble = 4'((int'(fs[11:8]) + int'(wrapTable[shadowLatch[5:4]])) % 16);
		end
		ramA = {nibble, fs[7:0], row};
		cpuWrite({1'b0, ramA}, 8'($random(seed)));
		@(posedge clk2MHz);
		framestoreAddr <= fs;
		rowAddr <= row;
		@(posedge clk2MHz);
		checkVideo <= 1'b1;
		expVideoData <= shadowRam[ramA];
		idle();
	endtask

	task automatic finishTest(input string name);
		int newFails;
		// Let the last assertion actions settle
		repeat (2) @(posedge clk2MHz);
		newFails = bbcMemSubsystem_inst.assertInst.failCount - failsBefore;
		failsBefore = bbcMemSubsystem_inst.assertInst.failCount;
		if (newFails == 0) begin
			passedTests++;
		end else begin
			failedTests++;
		end
		$display("%s: %s, %0d assertion failures", name, newFails == 0 ? "pass" : "FAIL",
			newFails);
	endtask

	initial begin
		logic [15:0] a;
		logic [13:0] fs;
		seed = 32'h7602_fa36;
		failsBefore = 0;
		passedTests = 0;
		failedTests = 0;
		CPU_RESETN = 1'b0;
		// Parked on a write to OS ROM, which stores nothing
		addr = 16'hC000;
		writeData = 8'h00;
		rnw = 1'b0;
		phi2 = 1'b1;
		latchWrite = 1'b0;
		latchAddr = 3'd0;
		latchData = 1'b0;
		framestoreAddr = 14'd0;
		rowAddr = 3'd0;
		checkRead = 1'b0;
		checkSheila = 1'b0;
		checkDecode = 1'b0;
		checkVideo = 1'b0;
		checkReset = 1'b0;
		latchCheckOn = 1'b0;
		expReadData = 8'h00;
		expVideoData = 8'h00;
		expSelect = '1;
		expRomOs = 1'b0;
		expRomAddr = '0;
		shadowLatch = 8'h00;

		@(posedge clk2MHz);
		checkReset <= 1'b1;
		latchCheckOn <= 1'b1;
		repeat (3) @(posedge clk2MHz);
		CPU_RESETN <= 1'b1;
		repeat (2) @(posedge clk2MHz);
		checkReset <= 1'b0;
		cpuRead(16'h8001, romModel(8'h01, 1'b0));
		finishTest("reset state");

		for (int i = 0; i < 64; i++) begin
			a = 16'($random(seed)) & 16'h7FFF;
			cpuWrite(a, 8'($random(seed)));
			cpuRead(a, shadowRam[a[14:0]]);
		end
		finishTest("RAM read after write");

		for (int r = 0; r < 2; r++) begin
			for (int off = 0; off < 256; off++) begin
				decodeStep(16'hFE00 | 16'(off), 1'(r));
			end
		end
		decodeStep(16'hFD30, 1'b0);
		decodeStep(16'hFF08, 1'b1);
		decodeStep(16'h7E20, 1'b0);
		idle();
		finishTest("I/O select decode");

		cpuRead(16'hC123, romModel(8'h23, 1'b1));
		cpuRead(16'hFFFC, romModel(8'hFC, 1'b1));
		cpuWrite(16'hFE30, 8'h00);
		cpuRead(16'h8234, romModel(8'h34, 1'b0));
		cpuWrite(16'hFE30, 8'h05);
		cpuRead(16'hA0FF, 8'hFF);
		cpuRead(16'hFE40, 8'h00);
		cpuWrite(16'hFE30, 8'h00);
		finishTest("ROM reads");

		latchOp(3'd3, 1'b1);
		for (int i = 0; i < 32; i++) begin
			latchOp(3'($random(seed)), 1'($random(seed)));
		end
		latchOp(3'd3, 1'b0);
		finishTest("addressable latch");

		for (int m = 0; m < 4; m++) begin
			latchOp(3'd4, m[0]);
			latchOp(3'd5, m[1]);
			fs = 14'($random(seed));
			videoCheck(fs & ~14'h1000, 3'($random(seed)));
			videoCheck(fs | 14'h1000, 3'($random(seed)));
		end
		finishTest("screen wraparound");

		$display("Tests: %0d passed, %0d failed, %0d assertion failures", passedTests,
			failedTests, failsBefore);
		if (failedTests == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
rtl/bbcMemPkg.sv
rtl/cpuBusIf.sv
rtl/sheilaDecoder.sv
rtl/systemControlRegs.sv
rtl/screenAddrMapper.sv
rtl/memoryArbiter.sv
rtl/bbcMemSubsystem.sv
dv/bbcMemSubsystem_assert.sv
dv/bbcMemTb.sv

//--- rtl/bbcMemPkg.sv
`default_nettype none

package bbcMemPkg;

	// Bus widths
	localparam int addrWidth = 16;
	localparam int ramAddrWidth = 15;
	localparam int dataWidth = 8;

	// Paged ROM bank that actually holds an image
	localparam int basicBank = 0;

	// Region of the CPU address map
	typedef enum logic [1:0] {
		ram,
		pagedRom,
		osRom,
		sheila
	} memRegionT;

	// Screen wrap offsets added to framestore bits 11:8
	// Index is latch bits {5,4}
	localparam logic [3:0] wrapOffsetTable [4] = '{4'd8, 4'd12, 4'd6, 4'd11};

	// Active-low chip selects of the FE page
	typedef struct packed {
		logic crtc;
		logic acia;
		logic videoUla;
		logic romSelect;
		logic via;
		logic userVia;
		logic fdc;
		logic adc;
		logic tube;
	} ioSelectT;

endpackage

`default_nettype wire

//--- rtl/bbcMemSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module bbcMemSubsystem import bbcMemPkg::*; #(
	parameter int romBankBits = 4
) (
	input logic clk2MHz,
	input logic CPU_RESETN,
	input logic [addrWidth-1:0] addr,
	input logic [dataWidth-1:0] writeData,
	input logic rnw,
	input logic phi2,
	input logic latchWrite,
	input logic [2:0] latchAddr,
	input logic latchData,
	input logic [13:0] framestoreAddr,
	input logic [2:0] rowAddr,
	input logic [dataWidth-1:0] romData,
	output logic [13:0] romAddr,
	output logic romOs,
	output logic [dataWidth-1:0] cpuReadData,
	output logic cpuReadHit,
	output logic [dataWidth-1:0] videoData,
	output logic videoValid,
	output logic nCrtc,
	output logic nAcia,
	output logic nVideoUla,
	output logic nRomSelect,
	output logic nVia,
	output logic nUserVia,
	output logic nFdc,
	output logic nAdc,
	output logic nTube,
	output logic autoscan
);

	memRegionT region;
	ioSelectT ioSelect;
	logic romSelWrite;
	logic [romBankBits-1:0] romBank;
	logic [7:0] latchBits;
	logic [ramAddrWidth-1:0] videoRamAddr;

	cpuBusIf bus ();

	assign bus.addr = addr;
	assign bus.writeData = writeData;
	assign bus.rnw = rnw;
	assign bus.phi2 = phi2;

	sheilaDecoder sheilaDecoder_inst (
		.bus(bus.decoderPort),
		.region(region),
		.ioSelect(ioSelect),
		.romSelWrite(romSelWrite)
	);

	systemControlRegs #(
		.romBankBits(romBankBits)
	) systemControlRegs_inst (
		.clk2MHz(clk2MHz),
		.CPU_RESETN(CPU_RESETN),
		.romSelWrite(romSelWrite),
		.writeData(writeData),
		.latchWrite(latchWrite),
		.latchAddr(latchAddr),
		.latchData(latchData),
		.romBank(romBank),
		.latchBits(latchBits)
	);

	// Latch bits 5:4 pick the screen size
	screenAddrMapper screenAddrMapper_inst (
		.framestoreAddr(framestoreAddr),
		.rowAddr(rowAddr),
		.screenMode(latchBits[5:4]),
		.videoRamAddr(videoRamAddr)
	);

	memoryArbiter #(
		.romBankBits(romBankBits)
	) memoryArbiter_inst (
		.clk2MHz(clk2MHz),
		.CPU_RESETN(CPU_RESETN),
		.bus(bus.memPort),
		.region(region),
		.romBank(romBank),
		.videoRamAddr(videoRamAddr),
		.romAddr(romAddr),
		.romOs(romOs),
		.romData(romData),
		.cpuReadData(cpuReadData),
		.cpuReadHit(cpuReadHit),
		.videoData(videoData),
		.videoValid(videoValid)
	);

	assign nCrtc = ioSelect.crtc;
	assign nAcia = ioSelect.acia;
	assign nVideoUla = ioSelect.videoUla;
	assign nRomSelect = ioSelect.romSelect;
	assign nVia = ioSelect.via;
	assign nUserVia = ioSelect.userVia;
	assign nFdc = ioSelect.fdc;
	assign nAdc = ioSelect.adc;
	assign nTube = ioSelect.tube;

	// Keyboard autoscan enable
	assign autoscan = latchBits[3];

endmodule

`default_nettype wire

//--- rtl/cpuBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface cpuBusIf import bbcMemPkg::*; ();

	logic [addrWidth-1:0] addr;
	logic [dataWidth-1:0] writeData;
	logic rnw;
	// High during a CPU cycle, low during a video cycle
	logic phi2;

	// Decoder needs no write data
	modport decoderPort (
		input addr,
		input rnw,
		input phi2
	);

	modport memPort (
		input addr,
		input writeData,
		input rnw,
		input phi2
	);

endinterface

`default_nettype wire

//--- rtl/memoryArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memoryArbiter import bbcMemPkg::*; #(
	parameter int romBankBits = 4
) (
	input logic clk2MHz,
	input logic CPU_RESETN,
	cpuBusIf.memPort bus,
	input memRegionT region,
	input logic [romBankBits-1:0] romBank,
	input logic [ramAddrWidth-1:0] videoRamAddr,
	output logic [13:0] romAddr,
	output logic romOs,
	input logic [dataWidth-1:0] romData,
	output logic [dataWidth-1:0] cpuReadData,
	output logic cpuReadHit,
	output logic [dataWidth-1:0] videoData,
	output logic videoValid
);

	logic [dataWidth-1:0] ramArray [2**ramAddrWidth];
	logic [ramAddrWidth-1:0] ramAddr;
	logic cpuRead;
	logic cpuWrite;
	logic basicSelected;

	// One RAM address port, owned by the CPU while phi2 is high
	assign ramAddr = bus.phi2 ? bus.addr[ramAddrWidth-1:0] : videoRamAddr;

	assign cpuRead = bus.phi2 & bus.rnw;
	assign cpuWrite = bus.phi2 & ~bus.rnw & (region == ram);
	assign basicSelected = (romBank == romBankBits'(basicBank));

	// ROM address goes out straight from the bus
	assign romAddr = bus.addr[13:0];
	assign romOs = (region == osRom);

	always_ff @(posedge clk2MHz) begin
		if (cpuWrite) begin
			ramArray[ramAddr] <= bus.writeData;
		end
		if (cpuRead) begin
			case (region)
				ram: cpuReadData <= ramArray[ramAddr];
				osRom: cpuReadData <= romData;
				// Empty sockets float high
				pagedRom: cpuReadData <= basicSelected ? romData : 8'hFF;
				default: cpuReadData <= 8'hFF;
			endcase
		end
		// Video fetch in the other half of the cycle
		if (!bus.phi2) begin
			videoData <= ramArray[ramAddr];
		end
	end

	always_ff @(posedge clk2MHz) begin
		if (!CPU_RESETN) begin
			cpuReadHit <= 1'b0;
			videoValid <= 1'b0;
		end else begin
			// I/O page reads are answered by the peripherals
			cpuReadHit <= cpuRead & (region != sheila);
			videoValid <= ~bus.phi2;
		end
	end

endmodule

`default_nettype wire

//--- rtl/screenAddrMapper.sv
`timescale 1ns/1ps
`default_nettype none

module screenAddrMapper import bbcMemPkg::*; (
	input logic [13:0] framestoreAddr,
	input logic [2:0] rowAddr,
	input logic [1:0] screenMode,
	output logic [ramAddrWidth-1:0] videoRamAddr
);

	logic [3:0] highNibble;
	logic [3:0] wrapOffset;
	logic [3:0] mappedNibble;

	assign highNibble = framestoreAddr[11:8];
	assign wrapOffset = wrapOffsetTable[screenMode];

	// Bit 12 flags an address past the top of RAM
	// 4-bit sum wraps back into screen memory
	always_comb begin
		if (framestoreAddr[12]) begin
			mappedNibble = highNibble + wrapOffset;
		end else begin
			mappedNibble = highNibble;
		end
	end

	// Row address selects the scan line within a character cell
	assign videoRamAddr = {mappedNibble, framestoreAddr[7:0], rowAddr};

endmodule

`default_nettype wire

//--- rtl/sheilaDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module sheilaDecoder import bbcMemPkg::*; (
	cpuBusIf.decoderPort bus,
	output memRegionT region,
	output ioSelectT ioSelect,
	output logic romSelWrite
);

	logic inIoPage;
	logic isWrite;
	logic [7:0] offset;

	assign inIoPage = (bus.addr[15:8] == 8'hFE);
	assign isWrite = ~bus.rnw;
	assign offset = bus.addr[7:0];

	// FE page takes priority over the OS ROM
	always_comb begin
		if (inIoPage) begin
			region = sheila;
		end else if (bus.addr[15:14] == 2'b11) begin
			region = osRom;
		end else if (bus.addr[15]) begin
			region = pagedRom;
		end else begin
			region = ram;
		end
	end

	always_comb begin
		ioSelect.crtc = ~(inIoPage & (offset[7:3] == 5'b00000));
		ioSelect.acia = ~(inIoPage & (offset[7:3] == 5'b00001));
		// Video ULA and ROM select are write-only
		ioSelect.videoUla = ~(inIoPage & (offset[7:4] == 4'h2) & isWrite);
		ioSelect.romSelect = ~(inIoPage & (offset[7:4] == 4'h3) & isWrite);
		ioSelect.via = ~(inIoPage & (offset[7:5] == 3'b010));
		ioSelect.userVia = ~(inIoPage & (offset[7:5] == 3'b011));
		ioSelect.fdc = ~(inIoPage & (offset[7:5] == 3'b100));
		// Offsets A0-BF select nothing
		ioSelect.adc = ~(inIoPage & (offset[7:5] == 3'b110));
		ioSelect.tube = ~(inIoPage & (offset[7:5] == 3'b111));
	end

	// Strobe only in the CPU half of the cycle
	assign romSelWrite = ~ioSelect.romSelect & bus.phi2;

endmodule

`default_nettype wire

//--- rtl/systemControlRegs.sv
`timescale 1ns/1ps
`default_nettype none

module systemControlRegs import bbcMemPkg::*; #(
	parameter int romBankBits = 4
) (
	input logic clk2MHz,
	input logic CPU_RESETN,
	input logic romSelWrite,
	input logic [dataWidth-1:0] writeData,
	input logic latchWrite,
	input logic [2:0] latchAddr,
	input logic latchData,
	output logic [romBankBits-1:0] romBank,
	output logic [7:0] latchBits
);

	logic [romBankBits-1:0] romBankNext;
	logic [7:0] latchBitsNext;

	// Bank number comes from the low bits of the written byte
	always_comb begin
		romBankNext = romBank;
		if (romSelWrite) begin
			romBankNext = writeData[romBankBits-1:0];
		end
	end

	// Addressable latch, one bit written at a time
	always_comb begin
		latchBitsNext = latchBits;
		if (latchWrite) begin
			latchBitsNext[latchAddr] = latchData;
		end
	end

	always_ff @(posedge clk2MHz) begin
		if (!CPU_RESETN) begin
			romBank <= '0;
			latchBits <= '0;
		end else begin
			romBank <= romBankNext;
			latchBits <= latchBitsNext;
		end
	end

endmodule

`default_nettype wire
